// File: hw/adc_unfold_cal.sv
`timescale 1ns/1ps

module adc_unfold_cal (
    input  logic                         clk_adc_i,
    input  logic                         rst_n_i,
    input  logic                         avg_tick_i,
    input  logic [rx_core_pkg::NADC-1:0] mag_i,
    input  logic                         sign_i,
    input  rx_core_pkg::rx_cfg_t         cfg_i,
    input  rx_core_pkg::adc_code_t       ext_offset_i,
    output rx_core_pkg::adc_code_t       dout_o,
    output rx_core_pkg::adc_code_t       offset_o
);

    import rx_core_pkg::*;

    // Room for 2^15 summed samples
    localparam int CNT_W = 2**NAVG_W;
    localparam int ACC_W = NADC + CNT_W;

    adc_code_t               mag_ext;
    adc_code_t               raw;
    adc_code_t               offset_cal;
    adc_code_t               offset_sel;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] acc_sum;
    logic [CNT_W-1:0]        avg_cnt;
    logic [CNT_W-1:0]        avg_last;
    logic                    avg_en;

    assign mag_ext = {1'b0, mag_i};

    // Capture and unfold, sign 1 means positive
    always_ff @(posedge clk_adc_i) begin
        raw <= sign_i ? mag_ext : -mag_ext;
    end

    assign avg_en   = avg_tick_i & cfg_i.en_pfd_cal;
    assign avg_last = (CNT_W'(1) << cfg_i.navg) - 1'b1;
    assign acc_sum  = acc + raw;

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc        <= '0;
            avg_cnt    <= '0;
            offset_cal <= '0;
        end else if (avg_en) begin
            if (avg_cnt == avg_last) begin
                // Mean of 2^navg samples
                offset_cal <= adc_code_t'(acc_sum >>> cfg_i.navg);
                acc        <= '0;
                avg_cnt    <= '0;
            end else begin
                acc        <= acc_sum;
                avg_cnt    <= avg_cnt + 1'b1;
            end
        end
    end

    assign offset_sel = cfg_i.en_ext_offset ? ext_offset_i : offset_cal;

    always_ff @(posedge clk_adc_i) begin
        dout_o <= raw - offset_sel;
    end

    assign offset_o = offset_cal;

endmodule

// File: hw/mm_cdr.sv
`timescale 1ns/1ps

module mm_cdr #(
    parameter int N_TI = 4
) (
    input  logic                   clk_adc_i,
    input  logic                   rst_n_i,
    input  logic                   tick_i,
    input  rx_core_pkg::adc_code_t din_i [N_TI-1:0],
    input  rx_core_pkg::rx_cfg_t   cfg_i,
    output rx_core_pkg::pi_code_t  pi_code_o
);

    import rx_core_pkg::*;

    localparam int PD_W  = NADC + 3 + $clog2(N_TI);
    localparam int INT_W = PD_W + 8;

    adc_code_t               y_last;
    adc_code_t               y_ext [N_TI:0];
    logic signed [PD_W-1:0]  pd_sum;
    logic signed [PD_W-1:0]  prop;
    logic signed [INT_W-1:0] integ;
    logic signed [INT_W-1:0] integ_nxt;
    pi_code_t                phase;

    // y times the decision +1 or -1
    function automatic logic signed [PD_W-1:0] mul_dec(adc_code_t y, logic dec_neg);
        logic signed [PD_W-1:0] y_w;
        y_w = y;
        return dec_neg ? -y_w : y_w;
    endfunction

    // Previous word's last slice goes in front
    always_comb begin
        y_ext[0] = y_last;
        for (int k = 0; k < N_TI; k++) begin
            y_ext[k+1] = din_i[k];
        end
    end

    always_comb begin
        pd_sum = '0;
        for (int k = 1; k <= N_TI; k++) begin
            pd_sum = pd_sum + mul_dec(y_ext[k-1], y_ext[k][NADC])
                            - mul_dec(y_ext[k], y_ext[k-1][NADC]);
        end
    end

    assign prop      = pd_sum >>> cfg_i.kp_shift;
    assign integ_nxt = integ + (pd_sum >>> cfg_i.ki_shift);

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            y_last <= '0;
            integ  <= '0;
            phase  <= '0;
        end else begin
            y_last <= din_i[N_TI-1];
            if (tick_i && cfg_i.cdr_en) begin
                integ <= integ_nxt;
                // Wraps modulo 2^NPI
                phase <= phase + pi_code_t'(integ_nxt) + pi_code_t'(prop);
            end
        end
    end

    assign pi_code_o = phase;

endmodule

// File: hw/pi_ctl_scaler.sv
`timescale 1ns/1ps

module pi_ctl_scaler (
    input  logic                  clk_adc_i,
    input  logic                  rst_n_i,
    input  rx_core_pkg::pi_code_t pi_code_i,
    input  rx_core_pkg::pi_cfg_t  pi_cfg_i,
    output rx_core_pkg::pi_code_t int_pi_ctl_o [rx_core_pkg::NOUT-1:0]
);

    import rx_core_pkg::*;

    pi_code_t         pi_shift [NOUT-1:0];
    logic [NPI-1:0]   scale    [NOUT-1:0];
    logic [2*NPI-1:0] product  [NOUT-1:0];

    always_comb begin
        for (int j = 0; j < NOUT; j++) begin
            pi_shift[j] = pi_code_i + pi_cfg_i.chan[j].offset;
            // Full scale is max_sel x 16
            scale[j]    = NPI'({pi_cfg_i.chan[j].max_sel, 4'b0000});
            product[j]  = pi_shift[j] * scale[j];
        end
    end

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int j = 0; j < NOUT; j++) begin
                int_pi_ctl_o[j] <= '0;
            end
        end else begin
            for (int j = 0; j < NOUT; j++) begin
                int_pi_ctl_o[j] <= product[j][2*NPI-1:NPI];
            end
        end
    end

endmodule

// File: hw/rx_core_pkg.sv
package rx_core_pkg;

    localparam int NADC        = 8;
    localparam int NPI         = 9;
    localparam int NOUT        = 4;
    localparam int NAVG_W      = 4;
    localparam int MAX_SEL_W   = 5;
    localparam int SNAP_AW     = 8;

    // Unfolded ADC sample, two's complement
    typedef logic signed [NADC:0] adc_code_t;

    typedef logic [NPI-1:0] pi_code_t;

    // Receiver configuration, 27 bits
    typedef struct packed {
        logic              en_pfd_cal;
        logic              en_ext_offset;
        logic [NAVG_W-1:0] navg;
        logic [3:0]        ndiv_avg;
        logic [3:0]        ndiv_cdr;
        logic [3:0]        kp_shift;
        logic [3:0]        ki_shift;
        logic              cdr_en;
        logic [3:0]        filler;
    } rx_cfg_t;

    // Settings of one interpolator output
    typedef struct packed {
        pi_code_t             offset;
        logic [MAX_SEL_W-1:0] max_sel;
    } pi_out_cfg_t;

    typedef struct packed {
        pi_out_cfg_t [NOUT-1:0] chan;
    } pi_cfg_t;

    typedef struct packed {
        logic [SNAP_AW-1:0] addr;
    } snap_req_t;

    typedef enum logic [1:0] {
        SNAP_IDLE  = 2'd0,
        SNAP_WRITE = 2'd1,
        SNAP_FULL  = 2'd2
    } snap_state_e;

endpackage

// File: hw/rx_digital_core.sv
`timescale 1ns/1ps

module rx_digital_core #(
    parameter int N_TI      = 4,
    parameter int MEM_DEPTH = 64
) (
    input  logic                                   clk_adc_i,
    input  logic                                   rst_n_i,
    input  logic [rx_core_pkg::NADC-1:0]           adc_mag_i [N_TI-1:0],
    input  logic [N_TI-1:0]                        adc_sign_i,
    input  rx_core_pkg::rx_cfg_t                   rx_cfg_i,
    input  rx_core_pkg::pi_cfg_t                   pi_cfg_i,
    input  rx_core_pkg::adc_code_t                 ext_offset_i [N_TI-1:0],
    input  logic                                   dump_start_i,
    input  logic                                   req_valid_i,
    output logic                                   req_ready_o,
    input  rx_core_pkg::snap_req_t                 req_i,
    output logic                                   rsp_valid_o,
    input  logic                                   rsp_ready_i,
    output logic [N_TI*(rx_core_pkg::NADC+1)-1:0]  rsp_data_o,
    output rx_core_pkg::pi_code_t                  pi_code_o,
    output rx_core_pkg::pi_code_t                  int_pi_ctl_o [rx_core_pkg::NOUT-1:0],
    output rx_core_pkg::adc_code_t                 pfd_offset_o [N_TI-1:0],
    output logic                                   snap_done_o
);

    import rx_core_pkg::*;

    logic      avg_tick;
    logic      cdr_tick;
    adc_code_t adc_dout [N_TI-1:0];

    // Enable ticks replace divided clocks
    tick_divider #(.DIV_W(4)) avg_div (
        .clk_adc_i (clk_adc_i),
        .rst_n_i   (rst_n_i),
        .ndiv_i    (rx_cfg_i.ndiv_avg),
        .tick_o    (avg_tick)
    );

    tick_divider #(.DIV_W(4)) cdr_div (
        .clk_adc_i (clk_adc_i),
        .rst_n_i   (rst_n_i),
        .ndiv_i    (rx_cfg_i.ndiv_cdr),
        .tick_o    (cdr_tick)
    );

    genvar k;
    generate
        for (k = 0; k < N_TI; k = k + 1) begin : g_slice
            adc_unfold_cal i_adc_unfold_cal (
                .clk_adc_i    (clk_adc_i),
                .rst_n_i      (rst_n_i),
                .avg_tick_i   (avg_tick),
                .mag_i        (adc_mag_i[k]),
                .sign_i       (adc_sign_i[k]),
                .cfg_i        (rx_cfg_i),
                .ext_offset_i (ext_offset_i[k]),
                .dout_o       (adc_dout[k]),
                .offset_o     (pfd_offset_o[k])
            );
        end
    endgenerate

    mm_cdr #(.N_TI(N_TI)) i_mm_cdr (
        .clk_adc_i (clk_adc_i),
        .rst_n_i   (rst_n_i),
        .tick_i    (cdr_tick),
        .din_i     (adc_dout),
        .cfg_i     (rx_cfg_i),
        .pi_code_o (pi_code_o)
    );

    pi_ctl_scaler i_pi_ctl_scaler (
        .clk_adc_i    (clk_adc_i),
        .rst_n_i      (rst_n_i),
        .pi_code_i    (pi_code_o),
        .pi_cfg_i     (pi_cfg_i),
        .int_pi_ctl_o (int_pi_ctl_o)
    );

    snapshot_memory #(
        .N_TI      (N_TI),
        .MEM_DEPTH (MEM_DEPTH)
    ) i_snapshot_memory (
        .clk_adc_i    (clk_adc_i),
        .rst_n_i      (rst_n_i),
        .din_i        (adc_dout),
        .dump_start_i (dump_start_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_data_o   (rsp_data_o),
        .snap_done_o  (snap_done_o)
    );

endmodule

// File: hw/snapshot_memory.sv
`timescale 1ns/1ps

module snapshot_memory #(
    parameter int N_TI      = 4,
    parameter int MEM_DEPTH = 64
) (
    input  logic                                   clk_adc_i,
    input  logic                                   rst_n_i,
    input  rx_core_pkg::adc_code_t                 din_i [N_TI-1:0],
    input  logic                                   dump_start_i,
    input  logic                                   req_valid_i,
    output logic                                   req_ready_o,
    input  rx_core_pkg::snap_req_t                 req_i,
    output logic                                   rsp_valid_o,
    input  logic                                   rsp_ready_i,
    output logic [N_TI*(rx_core_pkg::NADC+1)-1:0]  rsp_data_o,
    output logic                                   snap_done_o
);

    import rx_core_pkg::*;

    localparam int WORD_W = N_TI * (NADC + 1);
    localparam int AW     = $clog2(MEM_DEPTH);

    typedef struct packed {
        logic [WORD_W-1:0] data;
    } snap_rsp_t;

    snap_state_e       state;
    logic              dump_q;
    logic              dump_rise;
    logic [AW-1:0]     wptr;
    logic [WORD_W-1:0] din_word;
    logic [WORD_W-1:0] mem [MEM_DEPTH-1:0];
    logic              addr_ok;
    logic              req_fire;
    logic              rsp_valid_q;
    snap_rsp_t         rsp_q;

    // Slice 0 in the low bits
    always_comb begin
        for (int k = 0; k < N_TI; k++) begin
            din_word[k*(NADC+1) +: NADC+1] = din_i[k];
        end
    end

    assign dump_rise = dump_start_i & ~dump_q;

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state  <= SNAP_IDLE;
            dump_q <= 1'b0;
            wptr   <= '0;
        end else begin
            dump_q <= dump_start_i;
            case (state)
                SNAP_IDLE: begin
                    if (dump_rise) begin
                        state <= SNAP_WRITE;
                    end
                end
                SNAP_WRITE: begin
                    wptr <= wptr + 1'b1;
                    if (wptr == AW'(MEM_DEPTH - 1)) begin
                        state <= SNAP_FULL;
                    end
                end
                // One shot, only reset rearms
                default: begin
                    state <= SNAP_FULL;
                end
            endcase
        end
    end

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (state == SNAP_WRITE) begin
            mem[wptr] <= din_word;
        end
    end

    // One-entry response slot
    assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
    assign req_fire    = req_valid_i & req_ready_o;
    assign addr_ok     = req_i.addr < MEM_DEPTH;

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_adc_i) begin
        if (req_fire) begin
            rsp_q.data <= addr_ok ? mem[req_i.addr[AW-1:0]] : '0;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_data_o  = rsp_q.data;
    assign snap_done_o = (state == SNAP_FULL);

endmodule

// File: hw/tick_divider.sv
`timescale 1ns/1ps

module tick_divider #(
    parameter int DIV_W = 4
) (
    input  logic             clk_adc_i,
    input  logic             rst_n_i,
    input  logic [DIV_W-1:0] ndiv_i,
    output logic             tick_o
);

    logic [DIV_W-1:0] cnt;
    logic [DIV_W-1:0] cnt_cur;
    logic             armed;

    // First period after reset counts straight from ndiv_i
    assign cnt_cur = armed ? cnt : ndiv_i;

    always_ff @(posedge clk_adc_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt    <= '0;
            armed  <= 1'b0;
            tick_o <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (cnt_cur == '0) begin
                cnt    <= ndiv_i;
                tick_o <= 1'b1;
            end else begin
                cnt    <= cnt_cur - 1'b1;
                tick_o <= 1'b0;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the receiver core testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module rx_digital_core_tb \
        -f rx_digital_core.f --Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vrx_digital_core_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: rx_digital_core.f
hw/rx_core_pkg.sv
hw/tick_divider.sv
hw/adc_unfold_cal.sv
hw/mm_cdr.sv
hw/pi_ctl_scaler.sv
hw/snapshot_memory.sv
hw/rx_digital_core.sv
verif/rx_digital_core_tb.sv

// File: verif/rx_digital_core_tb.sv
`timescale 1ns/1ps

module rx_digital_core_tb;

    import rx_core_pkg::*;

    localparam int N_TI         = 4;
    localparam int MEM_DEPTH    = 64;
    localparam int WORD_W       = N_TI * (NADC + 1);
    localparam int CLK_HALF     = 10;
    localparam int DRV_DLY      = 2;
    localparam int RST_CYC      = 8;
    localparam int CAL_WAIT     = 40;
    localparam int DONE_WAIT    = 20;
    localparam int N_BP_READS   = 80;
    localparam int N_SCALE      = 10;
    // Cycle budget of all tests, doubled for the watchdog
    localparam int BUDGET_CYC   = 3 * RST_CYC + 2 * (MEM_DEPTH + 12) + (MEM_DEPTH + 8)
                                + CAL_WAIT + 30 + 4 * N_BP_READS + 80 + 5 * N_SCALE;
    localparam int WATCHDOG_CYC = 2 * BUDGET_CYC + 200;

    logic                 clk_adc;
    logic                 rst_n;
    logic [NADC-1:0]      adc_mag [N_TI-1:0];
    logic [N_TI-1:0]      adc_sign;
    rx_cfg_t              rx_cfg;
    pi_cfg_t              pi_cfg;
    adc_code_t            ext_offset [N_TI-1:0];
    logic                 dump_start;
    logic                 req_valid;
    logic                 req_ready;
    snap_req_t            rd_req;
    logic                 rsp_valid;
    logic                 rsp_ready;
    logic [WORD_W-1:0]    rsp_data;
    pi_code_t             pi_code;
    pi_code_t             int_pi_ctl [NOUT-1:0];
    adc_code_t            pfd_offset [N_TI-1:0];
    logic                 snap_done;

    logic [WORD_W-1:0]    snap_copy [MEM_DEPTH];
    logic [SNAP_AW-1:0]   rd_addrs [$];
    adc_code_t            cal_off [N_TI-1:0];
    int                   checks_run;

    rx_digital_core #(
        .N_TI      (N_TI),
        .MEM_DEPTH (MEM_DEPTH)
    ) i_rx_digital_core (
        .clk_adc_i    (clk_adc),
        .rst_n_i      (rst_n),
        .adc_mag_i    (adc_mag),
        .adc_sign_i   (adc_sign),
        .rx_cfg_i     (rx_cfg),
        .pi_cfg_i     (pi_cfg),
        .ext_offset_i (ext_offset),
        .dump_start_i (dump_start),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_i        (rd_req),
        .rsp_valid_o  (rsp_valid),
        .rsp_ready_i  (rsp_ready),
        .rsp_data_o   (rsp_data),
        .pi_code_o    (pi_code),
        .int_pi_ctl_o (int_pi_ctl),
        .pfd_offset_o (pfd_offset),
        .snap_done_o  (snap_done)
    );

    initial begin
        clk_adc = 1'b0;
        forever #CLK_HALF clk_adc = ~clk_adc;
    end

    task automatic end_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    initial begin
        #(WATCHDOG_CYC * 2 * CLK_HALF);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYC);
        end_with_failure();
    end

    // Reference models
    function automatic adc_code_t unfold_ref(input logic [NADC-1:0] mag, input logic sign,
                                             input adc_code_t off);
        int raw;
        raw = sign ? int'(mag) : -int'(mag);
        return adc_code_t'(raw - int'(off));
    endfunction

    function automatic adc_code_t avg_ref(input int samples [$], input int navg);
        int sum;
        sum = 0;
        foreach (samples[i]) begin
            sum += samples[i];
        end
        return adc_code_t'(sum >>> navg);
    endfunction

    function automatic pi_code_t scale_ref(input pi_code_t pi, input pi_code_t off,
                                           input logic [MAX_SEL_W-1:0] max_sel);
        int shifted;
        int full_scale;
        shifted    = (int'(pi) + int'(off)) % (1 << NPI);
        full_scale = int'(max_sel) * 16;
        return pi_code_t'((shifted * full_scale) >> NPI);
    endfunction

    function automatic logic [WORD_W-1:0] snap_ref(input logic [SNAP_AW-1:0] addr);
        if (addr < MEM_DEPTH) begin
            return snap_copy[addr];
        end
        return '0;
    endfunction

    // Mueller-Muller sum of a repeated word, last slice wraps to the front
    function automatic int pd_ref(input int y [N_TI]);
        int sum;
        int y_prev;
        int d_prev;
        int d_cur;
        sum = 0;
        for (int k = 0; k < N_TI; k++) begin
            y_prev = (k == 0) ? y[N_TI-1] : y[k-1];
            d_prev = (y_prev < 0) ? -1 : 1;
            d_cur  = (y[k] < 0) ? -1 : 1;
            sum += y_prev * d_cur - y[k] * d_prev;
        end
        return sum;
    endfunction

    task automatic check_code(input string name, input adc_code_t exp, input adc_code_t act);
        checks_run++;
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_pi(input string name, input pi_code_t exp, input pi_code_t act);
        checks_run++;
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
        checks_run++;
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_adc);
        #DRV_DLY;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic apply_reset();
        next_cycle();
        rst_n = 1'b0;
        wait_cycles(RST_CYC);
        rst_n = 1'b1;
    endtask

    task automatic drive_random_inputs();
        for (int k = 0; k < N_TI; k++) begin
            adc_mag[k]  = NADC'($urandom_range(0, 255));
            adc_sign[k] = 1'($urandom_range(0, 1));
        end
    endtask

    task automatic drive_pattern(input int y [N_TI]);
        for (int k = 0; k < N_TI; k++) begin
            adc_mag[k]  = NADC'((y[k] < 0) ? -y[k] : y[k]);
            adc_sign[k] = (y[k] >= 0);
        end
    endtask

    // Random samples while one snapshot fills, with the expected words kept aside
    task automatic capture_snapshot(input adc_code_t offs [N_TI-1:0]);
        logic [WORD_W-1:0] word;
        int                guard;
        for (int c = 0; c < MEM_DEPTH + 4; c++) begin
            next_cycle();
            drive_random_inputs();
            dump_start = (c >= 1);
            // Word 0 holds the inputs driven the cycle before the rise
            if (c < MEM_DEPTH) begin
                for (int k = 0; k < N_TI; k++) begin
                    word[k*(NADC+1) +: NADC+1] = unfold_ref(adc_mag[k], adc_sign[k], offs[k]);
                end
                snap_copy[c] = word;
            end
        end
        guard = 0;
        @(negedge clk_adc);
        while (snap_done !== 1'b1) begin
            if (guard == DONE_WAIT) begin
                $display("Snapshot capture never raised snap_done_o");
                end_with_failure();
            end
            guard++;
            @(negedge clk_adc);
        end
        next_cycle();
        dump_start = 1'b0;
    endtask

    // Issues rd_addrs in order; checks responses at the falling edge
    task automatic run_reads(input bit backpressure);
        logic [SNAP_AW-1:0] pending [$];
        logic [SNAP_AW-1:0] addr;
        logic [WORD_W-1:0]  held;
        bit                 stalled;
        int                 n_sent;
        int                 n_got;
        int                 guard;
        n_sent  = 0;
        n_got   = 0;
        guard   = 0;
        stalled = 1'b0;
        held    = '0;
        while (n_got < rd_addrs.size()) begin
            if (guard == 8 * rd_addrs.size() + 20) begin
                $display("Readback stalled with %0d of %0d responses", n_got, rd_addrs.size());
                end_with_failure();
            end
            guard++;
            next_cycle();
            req_valid = (n_sent < rd_addrs.size());
            if (n_sent < rd_addrs.size()) begin
                rd_req.addr = rd_addrs[n_sent];
            end
            rsp_ready = backpressure ? ($urandom_range(0, 2) != 0) : 1'b1;
            @(negedge clk_adc);
            if (rsp_valid && !rsp_ready && req_ready) begin
                $display("[FAIL] t=%0t req_ready_o expected 0 got 1 while a response stalls",
                         $time);
                end_with_failure();
            end
            if (stalled) begin
                check_word("rsp_data_o under stall", held, rsp_data);
            end
            stalled = rsp_valid && !rsp_ready;
            held    = rsp_data;
            if (rsp_valid && rsp_ready) begin
                if (pending.size() == 0) begin
                    $display("Response seen on rsp_valid_o with no request outstanding");
                    end_with_failure();
                end
                addr = pending.pop_front();
                check_word($sformatf("rsp_data_o[addr %0d]", addr), snap_ref(addr), rsp_data);
                n_got++;
            end
            if (req_valid && req_ready) begin
                pending.push_back(rd_addrs[n_sent]);
                n_sent++;
            end
        end
        next_cycle();
        req_valid = 1'b0;
        rsp_ready = 1'b1;
    endtask

    initial begin
        int                  samples [$];
        int                  alt [N_TI];
        int                  skew [N_TI];
        int                  pd;
        pi_code_t            pi_start;
        logic signed [NPI-1:0] step;

        void'($urandom(32'h7fd6_ae6f));
        checks_run = 0;
        rst_n      = 1'b0;
        rx_cfg     = '0;
        pi_cfg     = '0;
        dump_start = 1'b0;
        req_valid  = 1'b0;
        rd_req     = '0;
        rsp_ready  = 1'b1;
        adc_sign   = '0;
        for (int k = 0; k < N_TI; k++) begin
            adc_mag[k]    = '0;
            ext_offset[k] = '0;
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            snap_copy[i] = '0;
        end

        // External offset and unfolding
        drive_random_inputs();
        rx_cfg.en_ext_offset = 1'b1;
        for (int k = 0; k < N_TI; k++) begin
            ext_offset[k] = adc_code_t'(int'($urandom_range(0, 31)) - 16);
        end
        apply_reset();
        capture_snapshot(ext_offset);
        rd_addrs.delete();
        for (int a = 0; a < MEM_DEPTH + 2; a++) begin
            rd_addrs.push_back(SNAP_AW'(a));
        end
        rd_addrs.push_back(SNAP_AW'(200));
        run_reads(1'b0);

        // Offset calibration with one constant code per slice
        for (int k = 0; k < N_TI; k++) begin
            adc_mag[k]    = NADC'($urandom_range(0, 100));
            adc_sign[k]   = 1'($urandom_range(0, 1));
            ext_offset[k] = '0;
        end
        rx_cfg               = '0;
        rx_cfg.en_pfd_cal    = 1'b1;
        rx_cfg.navg          = 4'd3;
        rx_cfg.ndiv_avg      = 4'd0;
        apply_reset();
        wait_cycles(CAL_WAIT);
        @(negedge clk_adc);
        for (int k = 0; k < N_TI; k++) begin
            samples.delete();
            repeat (1 << 3) samples.push_back(int'(unfold_ref(adc_mag[k], adc_sign[k], '0)));
            cal_off[k] = avg_ref(samples, 3);
            check_code($sformatf("pfd_offset_o[%0d]", k), cal_off[k], pfd_offset[k]);
        end

        // Freeze, then a snapshot against the calibrated offsets
        next_cycle();
        rx_cfg.en_pfd_cal = 1'b0;
        drive_random_inputs();
        for (int c = 0; c < 20; c++) begin
            next_cycle();
            drive_random_inputs();
        end
        @(negedge clk_adc);
        for (int k = 0; k < N_TI; k++) begin
            check_code($sformatf("pfd_offset_o[%0d] frozen", k), cal_off[k], pfd_offset[k]);
        end
        capture_snapshot(cal_off);

        // Readback under back-pressure
        rd_addrs.delete();
        for (int i = 0; i < N_BP_READS; i++) begin
            rd_addrs.push_back(SNAP_AW'($urandom_range(0, MEM_DEPTH + 15)));
        end
        run_reads(1'b1);

        // CDR, symmetric data first
        next_cycle();
        rx_cfg.en_ext_offset = 1'b1;
        rx_cfg.ndiv_cdr      = 4'd3;
        rx_cfg.kp_shift      = 4'd4;
        rx_cfg.ki_shift      = 4'd6;
        alt  = '{50, -50, 50, -50};
        skew = '{60, 10, -60, -10};
        drive_pattern(alt);
        wait_cycles(4);
        @(negedge clk_adc);
        pi_start = pi_code;
        next_cycle();
        rx_cfg.cdr_en = 1'b1;
        wait_cycles(20);
        @(negedge clk_adc);
        check_pi("pi_code_o", pi_start, pi_code);

        // Skewed data pushes the phase
        next_cycle();
        rx_cfg.cdr_en = 1'b0;
        drive_pattern(skew);
        wait_cycles(4);
        pd = pd_ref(skew);
        @(negedge clk_adc);
        pi_start = pi_code;
        next_cycle();
        rx_cfg.cdr_en = 1'b1;
        wait_cycles(16);
        rx_cfg.cdr_en = 1'b0;
        wait_cycles(2);
        @(negedge clk_adc);
        step = pi_code - pi_start;
        checks_run++;
        if (step == 0 || ((step > 0) != (pd > 0))) begin
            $display("[FAIL] t=%0t pi_code_o expected a step with the sign of %0d got %0d",
                     $time, pd, step);
            end_with_failure();
        end

        // Interpolator scaling on a frozen code
        pi_start = pi_code;
        for (int n = 0; n < N_SCALE; n++) begin
            next_cycle();
            for (int j = 0; j < NOUT; j++) begin
                pi_cfg.chan[j].offset  = pi_code_t'($urandom_range(0, (1 << NPI) - 1));
                pi_cfg.chan[j].max_sel = MAX_SEL_W'($urandom_range(0, 31));
            end
            wait_cycles(3);
            @(negedge clk_adc);
            check_pi("pi_code_o held", pi_start, pi_code);
            for (int j = 0; j < NOUT; j++) begin
                check_pi($sformatf("int_pi_ctl_o[%0d]", j),
                         scale_ref(pi_code, pi_cfg.chan[j].offset, pi_cfg.chan[j].max_sel),
                         int_pi_ctl[j]);
            end
        end

        if (checks_run > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("No checks were executed");
            end_with_failure();
        end
    end

endmodule
